// File: logic/mixer_pkg.sv
`default_nettype none

package mixer_pkg;

  // width of one payload word
  localparam int DATA_W = 64;

  // channel tag carried with every output beat
  typedef enum logic {
    CH0 = 1'b0,
    CH1 = 1'b1
  } chan_t;

  // one output beat, tag in the top bit
  typedef struct packed {
    chan_t             chan;
    logic [DATA_W-1:0] data;
  } mix_beat_t;

  // fifo status seen by the requester and the fsm
  typedef struct packed {
    logic empty;       // no entries
    logic prog_empty;  // fewer than one burst stored
    logic prog_full;   // at or above the input threshold
  } fifo_flags_t;

endpackage

`default_nettype wire

// File: logic/chan_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module chan_fifo #(
  parameter int DEPTH     = 16,
  parameter int PROG_FULL = 12,
  parameter int BURST_LEN = 4
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              push,
  input  logic [mixer_pkg::DATA_W-1:0]      push_data,
  input  logic                              pop,
  output logic [mixer_pkg::DATA_W-1:0]      head,
  output logic [$clog2(DEPTH+1)-1:0]        level,
  output mixer_pkg::fifo_flags_t            flags
);

  import mixer_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;

  // storage, no reset needed
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (push) begin
      if (wr_ptr == PTR_W'(DEPTH - 1)) begin
        wr_ptr <= '0;  // wrap for non power of two depths
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (pop) begin
      if (rd_ptr == PTR_W'(DEPTH - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // fill level, push and pop may coincide
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level <= '0;
    end else begin
      case ({push, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  assign head = mem[rd_ptr];  // show-ahead, valid while not empty

  // flags follow the registered level
  assign flags.empty      = (level == '0);
  assign flags.prog_empty = (level < BURST_LEN);
  assign flags.prog_full  = (level >= PROG_FULL);

  // upstream must respect prog_full, so full is never reached
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    (level == DEPTH) |-> !push
  ) else $error("push into a full channel fifo");

  // the fsm only pops a non-empty channel
  a_no_underflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    pop |-> !flags.empty
  ) else $error("pop from an empty channel fifo");

endmodule

`default_nettype wire

// File: logic/read_requester.sv
`timescale 1ns/1ns
`default_nettype none

module read_requester #(
  parameter int DEPTH        = 16,
  parameter int BURST_LEN    = 4,
  parameter int FLUSH_CYCLES = 8
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [$clog2(DEPTH+1)-1:0] level,
  input  mixer_pkg::fifo_flags_t     flags,
  input  logic                       granted,
  output logic                       req
);

  import mixer_pkg::*;

  localparam int CNT_W = $clog2(FLUSH_CYCLES + 1);

  logic [CNT_W-1:0] wait_cnt;
  logic             thresh_hit;
  logic             count_en;
  logic             timer_hit;

  assign thresh_hit = (level >= BURST_LEN);  // a full burst is waiting

  // partial load sitting idle
  assign count_en  = !flags.empty && flags.prog_empty && !granted;
  assign timer_hit = count_en && (wait_cnt == CNT_W'(FLUSH_CYCLES - 1));

  // wait timer, restarts whenever the partial load condition breaks
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt <= '0;
    end else if (!count_en) begin
      wait_cnt <= '0;
    end else if (!timer_hit) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req <= 1'b0;
    end else if (granted) begin
      req <= 1'b0;  // served, drop until needed again
    end else if (thresh_hit || timer_hit) begin
      req <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/burst_counter.sv
`timescale 1ns/1ns
`default_nettype none

module burst_counter #(
  parameter int BURST_LEN = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic burst_start,
  input  logic beat_pop,
  output logic burst_done
);

  localparam int CNT_W = $clog2(BURST_LEN + 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt        <= '0;
      burst_done <= 1'b0;
    end else if (burst_start) begin
      cnt        <= '0;  // new grant
      burst_done <= 1'b0;
    end else if (beat_pop) begin
      cnt <= cnt + 1'b1;
      if (cnt == CNT_W'(BURST_LEN - 1)) begin
        burst_done <= 1'b1;  // last beat of this grant
      end
    end
  end

  a_cnt_bound : assert property (
    @(posedge clk) disable iff (!rst_n)
    cnt <= CNT_W'(BURST_LEN)
  ) else $error("burst count above burst length");

  // the fsm must stop popping once the burst is complete
  a_no_pop_after_done : assert property (
    @(posedge clk) disable iff (!rst_n)
    burst_done |-> !beat_pop
  ) else $error("pop after burst_done");

endmodule

`default_nettype wire

// File: logic/mixer_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module mixer_fsm (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         req0,
  input  logic                         req1,
  input  mixer_pkg::fifo_flags_t       flags0,
  input  mixer_pkg::fifo_flags_t       flags1,
  input  logic [mixer_pkg::DATA_W-1:0] head0,
  input  logic [mixer_pkg::DATA_W-1:0] head1,
  input  logic                         burst_done,
  output logic                         pop0,
  output logic                         pop1,
  output logic                         burst_start,
  output logic                         granted0,
  output logic                         granted1,
  output mixer_pkg::mix_beat_t         out_beat,
  output logic                         out_valid,
  input  logic                         out_ready
);

  import mixer_pkg::*;

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    GRANT0 = 2'd1,
    GRANT1 = 2'd2
  } state_t;

  state_t state_q;
  state_t state_d;
  chan_t  last_ch;
  logic   slot_free;

  assign granted0  = (state_q == GRANT0);
  assign granted1  = (state_q == GRANT1);
  assign slot_free = !out_valid || out_ready;  // slot empty or draining

  assign pop0 = granted0 && !flags0.empty && slot_free && !burst_done;
  assign pop1 = granted1 && !flags1.empty && slot_free && !burst_done;

  always_comb begin
    state_d     = state_q;
    burst_start = 1'b0;
    case (state_q)
      IDLE: begin
        // favour the channel not served last
        if (req0 && (!req1 || last_ch == CH1)) begin
          state_d     = GRANT0;
          burst_start = 1'b1;
        end else if (req1) begin
          state_d     = GRANT1;
          burst_start = 1'b1;
        end
      end
      GRANT0: begin
        if (burst_done || flags0.empty) begin
          state_d = IDLE;
        end
      end
      GRANT1: begin
        if (burst_done || flags1.empty) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      last_ch <= CH1;  // so ch0 wins the first tie
    end else begin
      state_q <= state_d;
      if (state_d == GRANT0 && state_q == IDLE) begin
        last_ch <= CH0;
      end else if (state_d == GRANT1 && state_q == IDLE) begin
        last_ch <= CH1;
      end
    end
  end

  // output slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (pop0 || pop1) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pop0) begin
      out_beat <= '{chan: CH0, data: head0};
    end else if (pop1) begin
      out_beat <= '{chan: CH1, data: head1};
    end
  end

  // a new grant has to start from a cleared beat count
  a_start_clears_done : assert property (
    @(posedge clk) disable iff (!rst_n)
    burst_start |=> !burst_done
  ) else $error("burst_done still set at the start of a grant");

endmodule

`default_nettype wire

// File: logic/two_ch_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module two_ch_mixer #(
  parameter int DEPTH        = 16,
  parameter int PROG_FULL    = 12,
  parameter int BURST_LEN    = 4,
  parameter int FLUSH_CYCLES = 8
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [mixer_pkg::DATA_W-1:0] ch0_data,
  input  logic                         ch0_valid,
  output logic                         ch0_ready,
  input  logic [mixer_pkg::DATA_W-1:0] ch1_data,
  input  logic                         ch1_valid,
  output logic                         ch1_ready,
  output mixer_pkg::mix_beat_t         out_beat,
  output logic                         out_valid,
  input  logic                         out_ready
);

  import mixer_pkg::*;

  localparam int LVL_W = $clog2(DEPTH + 1);

  logic              push0, push1;
  logic              pop0, pop1;
  logic [DATA_W-1:0] head0, head1;
  logic [LVL_W-1:0]  level0, level1;
  fifo_flags_t       flags0, flags1;
  logic              req0, req1;
  logic              granted0, granted1;
  logic              burst_start;
  logic              burst_done;

  // ready while below the programmable full level
  assign ch0_ready = !flags0.prog_full;
  assign ch1_ready = !flags1.prog_full;
  assign push0     = ch0_valid && ch0_ready;
  assign push1     = ch1_valid && ch1_ready;

  chan_fifo #(
    .DEPTH     (DEPTH),
    .PROG_FULL (PROG_FULL),
    .BURST_LEN (BURST_LEN)
  ) ch0_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push0),
    .push_data (ch0_data),
    .pop       (pop0),
    .head      (head0),
    .level     (level0),
    .flags     (flags0)
  );

  chan_fifo #(
    .DEPTH     (DEPTH),
    .PROG_FULL (PROG_FULL),
    .BURST_LEN (BURST_LEN)
  ) ch1_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push1),
    .push_data (ch1_data),
    .pop       (pop1),
    .head      (head1),
    .level     (level1),
    .flags     (flags1)
  );

  read_requester #(
    .DEPTH        (DEPTH),
    .BURST_LEN    (BURST_LEN),
    .FLUSH_CYCLES (FLUSH_CYCLES)
  ) ch0_req_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .level   (level0),
    .flags   (flags0),
    .granted (granted0),
    .req     (req0)
  );

  read_requester #(
    .DEPTH        (DEPTH),
    .BURST_LEN    (BURST_LEN),
    .FLUSH_CYCLES (FLUSH_CYCLES)
  ) ch1_req_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .level   (level1),
    .flags   (flags1),
    .granted (granted1),
    .req     (req1)
  );

  burst_counter #(
    .BURST_LEN (BURST_LEN)
  ) burst_counter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .burst_start (burst_start),
    .beat_pop    (pop0 || pop1),
    .burst_done  (burst_done)
  );

  mixer_fsm mixer_fsm_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req0        (req0),
    .req1        (req1),
    .flags0      (flags0),
    .flags1      (flags1),
    .head0       (head0),
    .head1       (head1),
    .burst_done  (burst_done),
    .pop0        (pop0),
    .pop1        (pop1),
    .burst_start (burst_start),
    .granted0    (granted0),
    .granted1    (granted1),
    .out_beat    (out_beat),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

endmodule

`default_nettype wire

// File: dv/tb_two_ch_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module tb_two_ch_mixer;

  import mixer_pkg::*;

  localparam int DEPTH        = 16;
  localparam int PROG_FULL    = 12;
  localparam int BURST_LEN    = 4;
  localparam int FLUSH_CYCLES = 8;

  logic              clk;
  logic              rst_n;
  logic [DATA_W-1:0] ch0_data;
  logic              ch0_valid;
  logic              ch0_ready;
  logic [DATA_W-1:0] ch1_data;
  logic              ch1_valid;
  logic              ch1_ready;
  mix_beat_t         out_beat;
  logic              out_valid;
  logic              out_ready;

  integer            seed;
  logic [DATA_W-1:0] q0 [$];  // accepted ch0 beats not yet delivered
  logic [DATA_W-1:0] q1 [$];
  logic [DATA_W-1:0] exp_head0;
  logic [DATA_W-1:0] exp_head1;
  logic              exp_avail0;
  logic              exp_avail1;
  logic              take_pend;  // output handshake at the coming rising edge
  chan_t             take_chan;
  logic              rr_active;  // burst order check armed
  int                rr_count;   // beats delivered while armed

  two_ch_mixer #(.DEPTH(DEPTH), .PROG_FULL(PROG_FULL), .BURST_LEN(BURST_LEN),
                 .FLUSH_CYCLES(FLUSH_CYCLES)) two_ch_mixer_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_error(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_timeout(input string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    $display("=== FAIL ===");
    $fatal(1, "wait expired");
  endtask

  function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  function automatic logic [DATA_W-1:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  // one clock of stimulus on the falling edge, with scoreboard upkeep
  task automatic drive_cycle(input logic v0, input logic v1, input logic rdy);
    @(negedge clk);
    if (take_pend) begin  // beat taken at the last rising edge
      if (take_chan == CH0 && q0.size() > 0) begin
        q0.delete(0);
      end else if (take_chan == CH1 && q1.size() > 0) begin
        q1.delete(0);
      end
      if (rr_active) begin
        rr_count++;
      end
    end
    ch0_valid = v0;
    ch1_valid = v1;
    ch0_data  = rand_word();
    ch1_data  = rand_word();
    out_ready = rdy;
    // ready only changes on the rising edge, so acceptance is known now
    if (v0 && ch0_ready) begin
      q0.push_back(ch0_data);
    end
    if (v1 && ch1_ready) begin
      q1.push_back(ch1_data);
    end
    take_pend  = out_valid && rdy;
    take_chan  = out_beat.chan;
    exp_avail0 = (q0.size() > 0);
    exp_avail1 = (q1.size() > 0);
    exp_head0  = exp_avail0 ? q0[0] : '0;
    exp_head1  = exp_avail1 ? q1[0] : '0;
  endtask

  task automatic wait_drained(input int limit, input string what);
    int cycles;
    cycles = 0;
    while (q0.size() > 0 || q1.size() > 0 || out_valid) begin
      if (cycles == limit) begin
        abort_timeout(what);
      end
      drive_cycle(1'b0, 1'b0, 1'b1);
      cycles++;
    end
  endtask

  a_ch0_order : assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && out_ready && out_beat.chan == CH0) |->
      (exp_avail0 && out_beat.data == exp_head0))
    else report_error("ch0 output beat is not the oldest accepted ch0 beat");

  a_ch1_order : assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && out_ready && out_beat.chan == CH1) |->
      (exp_avail1 && out_beat.data == exp_head1))
    else report_error("ch1 output beat is not the oldest accepted ch1 beat");

  // bursts alternate ch0, ch1, ch0, ch1
  a_rr_tag : assert property (@(posedge clk) disable iff (!rst_n)
    (rr_active && out_valid && out_ready) |->
      (out_beat.chan == (((rr_count / BURST_LEN) % 2 == 0) ? CH0 : CH1)))
    else report_error("output tag breaks the round robin burst order");

  a_hold_stalled : assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
    else report_error("out_beat changed while the sink stalled");

  initial begin
    int cycles;
    seed       = 99656;
    rst_n      = 1'b0;
    ch0_data   = '0;
    ch0_valid  = 1'b0;
    ch1_data   = '0;
    ch1_valid  = 1'b0;
    out_ready  = 1'b0;
    exp_head0  = '0;
    exp_head1  = '0;
    exp_avail0 = 1'b0;
    exp_avail1 = 1'b0;
    take_pend  = 1'b0;
    take_chan  = CH0;
    rr_active  = 1'b0;
    rr_count   = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    assert (!out_valid && ch0_ready && ch1_ready)
      else report_error("outputs not at their reset values");

    // preload both channels behind a stalled sink, then release it
    repeat (2 * BURST_LEN) drive_cycle(1'b1, 1'b1, 1'b0);
    rr_active = 1'b1;
    cycles    = 0;
    while (rr_count < 4 * BURST_LEN) begin
      if (cycles == 100) begin
        abort_timeout("the four round robin bursts");
      end
      drive_cycle(1'b0, 1'b0, 1'b1);
      cycles++;
    end
    rr_active = 1'b0;
    wait_drained(50, "both channels to drain after the bursts");

    drive_cycle(1'b0, 1'b1, 1'b1);  // lone ch1 beat, below threshold
    wait_drained(FLUSH_CYCLES + 20, "the lone ch1 beat to be flushed");

    // back-pressure on ch0
    cycles = 0;
    while (ch0_ready) begin
      if (cycles == 2 * DEPTH) begin
        abort_timeout("ch0_ready to fall under back-pressure");
      end
      drive_cycle(1'b1, 1'b0, 1'b0);
      cycles++;
    end
    assert (q0.size() < DEPTH)
      else report_error("ch0 accepted a full fifo depth before ready fell");
    repeat (8) drive_cycle(1'b1, 1'b0, 1'b0);  // stalled slot must hold
    wait_drained(100, "the back-pressured ch0 beats to arrive");

    // random traffic on both inputs with random sink stalls
    repeat (400) drive_cycle(rand_bit(), rand_bit(), rand_bit());
    wait_drained(300, "the random traffic to drain");

    repeat (4) drive_cycle(1'b0, 1'b0, 1'b1);
    assert (!out_valid && ch0_ready && ch1_ready)
      else report_error("mixer not idle after the traffic drained");
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
logic/mixer_pkg.sv
logic/chan_fifo.sv
logic/read_requester.sv
logic/burst_counter.sv
logic/mixer_fsm.sv
logic/two_ch_mixer.sv
dv/tb_two_ch_mixer.sv

// File: run_sim.sh
#!/bin/sh
# build and run the two channel mixer testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_two_ch_mixer --Mdir obj_dir -f project.f

./obj_dir/Vtb_two_ch_mixer > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
